// ==== list.f ====
verilog/xbar_pkg.sv
verilog/xbar_if.sv
verilog/ctrl_regs.sv
verilog/benes_stage.sv
verilog/benes.sv
verilog/benes_top.sv
bench/clk_gen.sv
bench/benes_asserts.sv
bench/benes_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module benes_tb -f list.f -o benes_sim

./obj_dir/benes_sim | tee sim.log

grep -q "RESULT: PASS" sim.log

// ==== bench/benes_tb.sv ====
`timescale 1ns/100ps

module benes_tb;
    import xbar_pkg::*;

    localparam int TIMEOUT = 1000;

    logic                  xif;
    logic                  rst_n;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    axi_resp_t             bresp;
    logic                  bvalid;
    logic                  bready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    axi_resp_t             rresp;
    logic                  rvalid;
    logic                  rready;
    lane_word_t            in_lane [8];
    logic                  in_valid;
    logic                  in_ready;
    lane_word_t            out_lane [8];
    logic                  out_valid;
    logic                  out_ready;

    integer         seed = 32'hf4856907;
    int             errors = 0;
    int             n_out = 0;
    logic [127:0]   vec_q [$]; // vectors in flight, oldest first.
    logic [19:0]    ctl_q [$];
    logic [31:0]    model_ctrl = '0;
    logic [3:0]     pend_addr;
    logic [31:0]    pend_data;
    logic [3:0]     pend_strb;
    logic           b_prev = 1'b0;
    logic           rand_ready = 1'b0;

    clk_gen u_clk (.xif(xif), .rst_n(rst_n));

    benes_top dut (.*);

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // stage by stage, 0 passes a pair and 1 swaps it.
    function automatic logic [127:0] permute(input logic [127:0] v, input logic [19:0] c);
        logic [127:0] r;
        int d;
        int lo;
        r = v;
        for (int s = 0; s < 5; s++) begin
            d = (s < 3) ? (1 << s) : (1 << (4 - s));
            for (int k = 0; k < 4; k++) begin
                lo = (k / d) * 2 * d + (k % d);
                if (c[s*4+k]) begin
                    r[16*lo +: 16]     = v[16*(lo+d) +: 16];
                    r[16*(lo+d) +: 16] = v[16*lo +: 16];
                end
            end
            v = r;
        end
        return r;
    endfunction

    // input side monitor, also tracks the settings a vector enters under.
    always @(posedge xif) begin
        if (bvalid && !b_prev) begin
            check_value("drained before write", 32'd0, vec_q.size());
            if (pend_addr == ADDR_CTRL) begin
                for (int b = 0; b < 4; b++) begin
                    if (pend_strb[b]) model_ctrl[8*b +: 8] = pend_data[8*b +: 8];
                end
            end
        end
        b_prev <= bvalid;
        if (in_valid && in_ready) begin
            vec_q.push_back({in_lane[7], in_lane[6], in_lane[5], in_lane[4],
                             in_lane[3], in_lane[2], in_lane[1], in_lane[0]});
            ctl_q.push_back(model_ctrl[19:0]);
        end
    end

    always @(posedge xif) begin
        logic [127:0] exp;
        if (out_valid && out_ready) begin
            if (vec_q.size() == 0) begin
                errors++;
                $display("an output vector appeared with nothing sent");
            end else begin
                exp = permute(vec_q.pop_front(), ctl_q.pop_front());
                for (int i = 0; i < 8; i++) begin
                    check_value($sformatf("lane %0d", i), {16'd0, exp[16*i +: 16]},
                                {16'd0, out_lane[i]});
                end
            end
            n_out++;
        end
    end

    always @(posedge xif) begin
        logic [31:0] r;
        r = $random(seed);
        out_ready <= rand_ready ? r[0] : 1'b1;
    end

    task automatic send_vectors(input int n);
        logic [31:0] r;
        int t;
        for (int v = 0; v < n; v++) begin
            for (int i = 0; i < 8; i++) begin
                r = $random(seed);
                in_lane[i] <= r[15:0];
            end
            in_valid <= 1'b1;
            t = 0;
            do begin
                @(posedge xif);
                t++;
            end while (!in_ready && t < TIMEOUT);
            if (t >= TIMEOUT) begin
                errors++;
                $display("input side never became ready");
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input axi_resp_t exp);
        logic aw_done;
        logic w_done;
        int t;
        pend_addr = addr;
        pend_data = data;
        pend_strb = strb;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        t = 0;
        while (!(aw_done && w_done) && t < TIMEOUT) begin
            @(posedge xif);
            t++;
            if (awvalid && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        if (!(aw_done && w_done)) begin
            errors++;
            $display("write to address %h was never accepted", addr);
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end
        t = 0;
        do begin
            @(posedge xif);
            t++;
        end while (!bvalid && t < TIMEOUT);
        if (!bvalid) begin
            errors++;
            $display("write to address %h got no response", addr);
        end
        check_value("write response", {30'd0, exp}, {30'd0, bresp});
        repeat (2) @(posedge xif); // let the response wait for bready.
        bready <= 1'b1;
        @(posedge xif);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input logic [31:0] exp_data,
                            input axi_resp_t exp);
        int t;
        araddr  <= addr;
        arvalid <= 1'b1;
        t = 0;
        do begin
            @(posedge xif);
            t++;
        end while (!arready && t < TIMEOUT);
        if (!arready) begin
            errors++;
            $display("read of address %h was never accepted", addr);
        end
        arvalid <= 1'b0;
        t = 0;
        do begin
            @(posedge xif);
            t++;
        end while (!rvalid && t < TIMEOUT);
        if (!rvalid) begin
            errors++;
            $display("read of address %h got no response", addr);
        end
        check_value("read data", exp_data, rdata);
        check_value("read response", {30'd0, exp}, {30'd0, rresp});
        @(posedge xif); // let the response wait for rready.
        rready <= 1'b1;
        @(posedge xif);
        rready <= 1'b0;
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (vec_q.size() != 0 && t < TIMEOUT) begin
            @(posedge xif);
            t++;
        end
        if (t >= TIMEOUT) begin
            errors++;
            $display("vectors still in flight after the timeout");
        end
    endtask

    initial begin
        logic [31:0] r;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b0;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        in_valid <= 1'b0;
        out_ready <= 1'b1;
        for (int i = 0; i < 8; i++) in_lane[i] <= '0;
        @(posedge rst_n);
        @(posedge xif);

        send_vectors(5); // reset settings give identity.
        wait_drain();
        r = $random(seed);
        axi_write(ADDR_CTRL, r, 4'hf, OKAY);
        send_vectors(40);
        wait_drain();
        axi_read(ADDR_COUNT, 32'd45, OKAY);
        rand_ready = 1'b1;
        send_vectors(30);
        wait_drain();
        rand_ready = 1'b0;
        fork
            send_vectors(20);
            begin
                repeat (6) @(posedge xif);
                axi_write(ADDR_CTRL, 32'h000c_5a3e, 4'hf, OKAY);
            end
        join
        wait_drain();
        axi_write(ADDR_CTRL, 32'h1234_abcd, 4'b0101, OKAY);
        axi_read(ADDR_CTRL, 32'h0034_5acd, OKAY);
        axi_write(ADDR_COUNT, 32'hffff_ffff, 4'hf, SLVERR);
        axi_write(4'hc, 32'hffff_ffff, 4'hf, SLVERR);
        axi_read(ADDR_CTRL, 32'h0034_5acd, OKAY);
        axi_read(ADDR_COUNT, 32'd95, OKAY); // every vector sent so far.
        axi_read(4'h8, 32'd0, SLVERR);

        $display("vectors delivered %0d, errors %0d", n_out, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/benes_asserts.sv ====
`timescale 1ns/100ps

module benes_asserts (
    input logic xif,
    input logic rst_n,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic busy
);

    // a response must wait for its ready.
    a_bvalid_hold: assert property (@(posedge xif) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("write response dropped before it was accepted");

    a_rvalid_hold: assert property (@(posedge xif) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("read response dropped before it was accepted");

    // the commit edge saw an empty network.
    a_bvalid_idle: assert property (@(posedge xif) disable iff (!rst_n)
        $rose(bvalid) |-> !$past(busy))
        else $error("write response raised while the network was busy");

endmodule

bind ctrl_regs benes_asserts u_asserts (
    .xif    (xif),
    .rst_n  (rst_n),
    .bvalid (bvalid),
    .bready (bready),
    .rvalid (rvalid),
    .rready (rready),
    .busy   (busy)
);

// ==== bench/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
    output logic xif,
    output logic rst_n
);

    initial begin
        xif   = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(posedge xif);
        rst_n <= 1'b1; // released on the edge after the fourth cycle.
    end

    always #4 xif = ~xif; // 8 ns period.

endmodule

// ==== verilog/benes_top.sv ====
`timescale 1ns/100ps

module benes_top #(
    parameter int SIZE = 8,
    parameter logic [7:0] REGISTER_MASK = 8'hff
) (
    input  logic                            xif,
    input  logic                            rst_n,
    input  logic [xbar_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     wdata,
    input  logic [3:0]                      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output xbar_pkg::axi_resp_t             bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [xbar_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output xbar_pkg::axi_resp_t             rresp,
    output logic                            rvalid,
    input  logic                            rready,
    input  xbar_pkg::lane_word_t            in_lane [SIZE],
    input  logic                            in_valid,
    output logic                            in_ready,
    output xbar_pkg::lane_word_t            out_lane [SIZE],
    output logic                            out_valid,
    input  logic                            out_ready
);

    localparam int TAGWIDTH = $clog2(SIZE);
    localparam int STAGES = 2 * TAGWIDTH - 1;
    localparam int BITWIDTH = STAGES * (SIZE / 2);

    logic [BITWIDTH-1:0] ctrl_word;
    logic                hold;
    logic                busy;
    logic                out_fire;

    ctrl_regs #(
        .SIZE (SIZE)
    ) u_regs (
        .xif       (xif),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .ctrl_word (ctrl_word),
        .hold      (hold),
        .busy      (busy),
        .out_fire  (out_fire)
    );

    benes #(
        .SIZE          (SIZE),
        .REGISTER_MASK (REGISTER_MASK)
    ) u_net (
        .xif       (xif),
        .rst_n     (rst_n),
        .ctrl_word (ctrl_word),
        .hold      (hold),
        .busy      (busy),
        .out_fire  (out_fire),
        .in_lane   (in_lane),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_lane  (out_lane),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== verilog/benes.sv ====
`timescale 1ns/100ps

module benes #(
    parameter int SIZE = 8,
    parameter logic [7:0] REGISTER_MASK = 8'hff,
    localparam int TAGWIDTH = $clog2(SIZE),
    localparam int STAGES = 2 * TAGWIDTH - 1,
    localparam int BITWIDTH = STAGES * (SIZE / 2)
) (
    input  logic                 xif,
    input  logic                 rst_n,
    input  logic [BITWIDTH-1:0]  ctrl_word,
    input  logic                 hold,
    output logic                 busy,
    output logic                 out_fire,
    input  xbar_pkg::lane_word_t in_lane [SIZE],
    input  logic                 in_valid,
    output logic                 in_ready,
    output xbar_pkg::lane_word_t out_lane [SIZE],
    output logic                 out_valid,
    input  logic                 out_ready
);

    logic [STAGES-1:0] occ;

    xbar_if #(.SIZE(SIZE)) link [STAGES+1] (); // link s feeds stage s.

    // hold blocks both sides of the entry handshake.
    assign link[0].lane  = in_lane;
    assign link[0].valid = in_valid && !hold;
    assign in_ready      = link[0].ready && !hold;

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        // the last column is never registered.
        localparam bit STAGE_REG = (s < STAGES - 1) ? REGISTER_MASK[s] : 1'b0;

        benes_stage #(
            .SIZE       (SIZE),
            .STAGE      (s),
            .REGISTERED (STAGE_REG)
        ) u_stage (
            .xif      (xif),
            .rst_n    (rst_n),
            .ctrl     (ctrl_word[s*(SIZE/2) +: SIZE/2]),
            .up       (link[s]),
            .down     (link[s+1]),
            .occupied (occ[s])
        );
    end

    assign out_lane            = link[STAGES].lane;
    assign out_valid           = link[STAGES].valid;
    assign link[STAGES].ready  = out_ready;

    assign busy     = |occ;
    assign out_fire = out_valid && out_ready; // one pulse per delivered vector.

endmodule

// ==== verilog/benes_stage.sv ====
`timescale 1ns/100ps

module benes_stage #(
    parameter int SIZE = 8,
    parameter int STAGE = 0,
    parameter bit REGISTERED = 1'b1
) (
    input  logic              xif,
    input  logic              rst_n,
    input  logic [SIZE/2-1:0] ctrl,
    xbar_if.dst               up,
    xbar_if.src               down,
    output logic              occupied
);
    import xbar_pkg::*;

    localparam int TAGWIDTH = $clog2(SIZE);
    localparam int STAGES = 2 * TAGWIDTH - 1;
    // butterfly spacing, widening to the middle column and narrowing after it.
    localparam int D = (STAGE < TAGWIDTH) ? (1 << STAGE) : (1 << (STAGES - 1 - STAGE));

    lane_word_t sw [SIZE]; // switched vector.

    for (genvar k = 0; k < SIZE / 2; k++) begin : g_switch
        localparam int LO = (k / D) * 2 * D + (k % D);
        localparam int HI = LO + D;

        assign sw[LO] = ctrl[k] ? up.lane[HI] : up.lane[LO]; // 1 swaps the pair.
        assign sw[HI] = ctrl[k] ? up.lane[LO] : up.lane[HI];
    end

    if (REGISTERED) begin : g_reg
        lane_word_t lane_q [SIZE];
        logic       valid_q;
        logic       load;

        assign load = down.ready || !valid_q; // advance when drained or empty.

        always_ff @(posedge xif or negedge rst_n) begin
            if (!rst_n) begin
                valid_q <= 1'b0;
            end else if (load) begin
                valid_q <= up.valid;
            end
        end

        always_ff @(posedge xif) begin
            if (load && up.valid) begin
                lane_q <= sw;
            end
        end

        assign up.ready   = load;
        assign down.lane  = lane_q;
        assign down.valid = valid_q;
        assign occupied   = valid_q;
    end else begin : g_comb
        assign up.ready   = down.ready;
        assign down.lane  = sw;
        assign down.valid = up.valid;
        assign occupied   = 1'b0; // holds nothing between edges.
    end

endmodule

// ==== verilog/ctrl_regs.sv ====
`timescale 1ns/100ps

module ctrl_regs #(
    parameter int SIZE = 8,
    localparam int TAGWIDTH = $clog2(SIZE),
    localparam int STAGES = 2 * TAGWIDTH - 1,
    localparam int BITWIDTH = STAGES * (SIZE / 2)
) (
    input  logic                            xif,
    input  logic                            rst_n,
    input  logic [xbar_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [31:0]                     wdata,
    input  logic [3:0]                      wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output xbar_pkg::axi_resp_t             bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [xbar_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [31:0]                     rdata,
    output xbar_pkg::axi_resp_t             rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [BITWIDTH-1:0]             ctrl_word,
    output logic                            hold,
    input  logic                            busy,
    input  logic                            out_fire
);
    import xbar_pkg::*;

    logic                  aw_held;
    logic                  w_held;
    logic [ADDR_WIDTH-1:0] awaddr_q;
    logic [31:0]           wdata_q;
    logic [3:0]            wstrb_q;
    logic [31:0]           ctrl_q;
    logic [31:0]           count_q;
    logic                  commit;
    logic                  wr_ctrl;
    logic [31:0]           rd_data;
    axi_resp_t             rd_resp;

    assign awready = !aw_held;
    assign wready  = !w_held;
    assign arready = !rvalid; // one read outstanding at a time.

    // settings only change once the network has drained.
    assign commit  = aw_held && w_held && !busy && !bvalid;
    assign wr_ctrl = (awaddr_q == ADDR_CTRL);

    assign hold      = aw_held || w_held; // stop new vectors while a write waits.
    assign ctrl_word = ctrl_q[BITWIDTH-1:0];

    always_ff @(posedge xif or negedge rst_n) begin
        if (!rst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            ctrl_q  <= '0;
        end else begin
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            if (commit) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                if (wr_ctrl) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb_q[b]) begin
                            ctrl_q[8*b +: 8] <= wdata_q[8*b +: 8];
                        end
                    end
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge xif) begin
        if (awvalid && awready) begin
            awaddr_q <= awaddr;
        end
        if (wvalid && wready) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (commit) begin
            bresp <= wr_ctrl ? OKAY : SLVERR; // count is read only.
        end
    end

    always_ff @(posedge xif or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (out_fire) begin
            count_q <= count_q + 32'd1;
        end
    end

    always_comb begin
        case (araddr)
            ADDR_CTRL: begin
                rd_data = ctrl_q;
                rd_resp = OKAY;
            end
            ADDR_COUNT: begin
                rd_data = count_q;
                rd_resp = OKAY;
            end
            default: begin
                rd_data = '0;
                rd_resp = SLVERR;
            end
        endcase
    end

    always_ff @(posedge xif or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge xif) begin
        if (arvalid && arready) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

// ==== verilog/xbar_if.sv ====
`timescale 1ns/100ps

interface xbar_if #(
    parameter int SIZE = 8
);
    import xbar_pkg::*;

    lane_word_t lane [SIZE]; // one word per lane.
    logic       valid;
    logic       ready;

    // the upstream side of a link.
    modport src (
        output lane,
        output valid,
        input  ready
    );

    modport dst (
        input  lane,
        input  valid,
        output ready
    );

endinterface

// ==== verilog/xbar_pkg.sv ====
package xbar_pkg;

    parameter int LANE_WIDTH = 16; // bits per crossbar lane.

    typedef logic [LANE_WIDTH-1:0] lane_word_t;

    // AXI response codes, only the two this slave uses.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    parameter int ADDR_WIDTH = 4; // byte address into the register file.

    parameter logic [ADDR_WIDTH-1:0] ADDR_CTRL  = 4'h0; // switch settings, r/w.
    parameter logic [ADDR_WIDTH-1:0] ADDR_COUNT = 4'h4; // vectors delivered, read only.

endpackage
